// ==== logic/shell_pkg.sv ====
////////////////////
// video and audio output shell definitions
// bus widths, register map, reset defaults
////////////////////

`default_nettype none

package shell_pkg;

    ////////////////////
    // vector types

    // apb byte address and data word
    typedef logic [11:0] apb_addr_t;
    typedef logic [31:0] apb_data_t;
    // pixel and line counts, also the window bounds
    typedef logic [10:0] count_t;
    // one palette entry
    typedef logic [7:0]  grey_t;
    // {white, black} from the game core
    typedef logic [1:0]  colour_code_t;
    typedef logic [15:0] sample_t;
    typedef logic [23:0] rgb_t;

    ////////////////////
    // register map

    localparam apb_addr_t REG_ID      = 12'h000;
    localparam apb_addr_t REG_PALETTE = 12'h004;
    localparam apb_addr_t REG_HWIN    = 12'h008;
    localparam apb_addr_t REG_VWIN    = 12'h00C;
    localparam apb_addr_t REG_FRAMES  = 12'h010;

    localparam apb_data_t SHELL_ID    = 32'h444D4E31;

    ////////////////////
    // reset defaults

    // entry n sits in byte n
    localparam apb_data_t PALETTE_RST = 32'hFF865000;
    localparam count_t    H_START_RST = 11'd6;
    localparam count_t    H_END_RST   = 11'd326;
    localparam count_t    V_START_RST = 11'd0;
    localparam count_t    V_END_RST   = 11'd241;

    // i2s channel, lrck low is left
    typedef enum logic {
        I2S_LEFT  = 1'b0,
        I2S_RIGHT = 1'b1
    } i2s_state_e;

endpackage

`default_nettype wire

// ==== logic/shell_cfg_if.sv ====
////////////////////
// configuration bundle from the register block
// to the window and video stages, frame status back
////////////////////

`timescale 1ns/100ps
`default_nettype none

interface shell_cfg_if;

    // grey levels, index is the colour code
    shell_pkg::grey_t [3:0] palette;
    // horizontal window bounds in pixels
    shell_pkg::count_t      h_start;
    shell_pkg::count_t      h_end;
    // vertical window bounds in lines
    shell_pkg::count_t      v_start;
    shell_pkg::count_t      v_end;
    // one cycle per closed vertical window
    logic                   frame_tick;

    // register block side
    modport decode (
        output palette, h_start, h_end, v_start, v_end,
        input  frame_tick
    );

    // window counters
    modport window (
        input  h_start, h_end, v_start, v_end,
        output frame_tick
    );

    // palette lookup
    modport video (
        input  palette
    );

endinterface

`default_nettype wire

// ==== logic/apb_reg_decode.sv ====
////////////////////
// apb slave for the shell registers
// palette, window bounds, id word, frame counter
////////////////////

`timescale 1ns/100ps
`default_nettype none

module apb_reg_decode (
    input  wire                        clk_sys,
    input  wire                        rst_n,
    input  wire                        psel,
    input  wire                        penable,
    input  wire                        pwrite,
    input  wire shell_pkg::apb_addr_t  paddr,
    input  wire shell_pkg::apb_data_t  pwdata,
    output shell_pkg::apb_data_t       prdata,
    output logic                       pready,
    output logic                       pslverr,
    shell_cfg_if.decode                cfg
);

    logic                 setup;
    logic                 wr_en;
    logic                 addr_ok;
    logic                 ro_hit;
    shell_pkg::apb_data_t rd_mux;
    shell_pkg::apb_data_t palette_q;
    shell_pkg::apb_data_t frames_q;
    shell_pkg::count_t    h_start_q;
    shell_pkg::count_t    h_end_q;
    shell_pkg::count_t    v_start_q;
    shell_pkg::count_t    v_end_q;

    // no wait states
    assign pready = 1'b1;

    // setup phase, read data and error get latched here
    assign setup  = psel & ~penable;
    // id and frames are read only
    assign ro_hit = (paddr == shell_pkg::REG_ID) || (paddr == shell_pkg::REG_FRAMES);
    // write lands at the end of the access cycle
    assign wr_en  = psel & penable & pwrite & addr_ok & ~ro_hit;

    ////////////////////
    // address decode

    always_comb begin
        addr_ok = 1'b1;
        rd_mux  = '0;
        case (paddr)
            shell_pkg::REG_ID:      rd_mux = shell_pkg::SHELL_ID;
            shell_pkg::REG_PALETTE: rd_mux = palette_q;
            // end in 26:16, start in 10:0
            shell_pkg::REG_HWIN:    rd_mux = {5'd0, h_end_q, 5'd0, h_start_q};
            shell_pkg::REG_VWIN:    rd_mux = {5'd0, v_end_q, 5'd0, v_start_q};
            shell_pkg::REG_FRAMES:  rd_mux = frames_q;
            default:                addr_ok = 1'b0;
        endcase
    end

    // response for the following access cycle, cleared otherwise
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end else if (setup) begin
            prdata  <= pwrite ? '0 : rd_mux;
            pslverr <= ~addr_ok | (pwrite & ro_hit);
        end else begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end
    end

    ////////////////////
    // config registers

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            palette_q <= shell_pkg::PALETTE_RST;
            h_start_q <= shell_pkg::H_START_RST;
            h_end_q   <= shell_pkg::H_END_RST;
            v_start_q <= shell_pkg::V_START_RST;
            v_end_q   <= shell_pkg::V_END_RST;
        end else if (wr_en) begin
            if (paddr == shell_pkg::REG_PALETTE) begin
                palette_q <= pwdata;
            end
            if (paddr == shell_pkg::REG_HWIN) begin
                h_end_q   <= pwdata[26:16];
                h_start_q <= pwdata[10:0];
            end
            if (paddr == shell_pkg::REG_VWIN) begin
                v_end_q   <= pwdata[26:16];
                v_start_q <= pwdata[10:0];
            end
        end
    end

    // closed vertical windows, wraps at 32 bits
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            frames_q <= '0;
        end else if (cfg.frame_tick) begin
            frames_q <= frames_q + 32'd1;
        end
    end

    assign cfg.palette = palette_q;
    assign cfg.h_start = h_start_q;
    assign cfg.h_end   = h_end_q;
    assign cfg.v_start = v_start_q;
    assign cfg.v_end   = v_end_q;

endmodule

`default_nettype wire

// ==== logic/blank_window.sv ====
////////////////////
// active window rebuild
// counts pixels and lines from the end of source blanking
////////////////////

`timescale 1ns/100ps
`default_nettype none

module blank_window (
    input  wire         clk_sys,
    input  wire         rst_n,
    input  wire         pix_ce,
    input  wire         src_hblank,
    input  wire         src_vblank,
    shell_cfg_if.window cfg,
    output logic        window_hblank,
    output logic        window_vblank
);

    logic              hbl_prev;
    logic              vbl_prev;
    logic              line_start;
    logic              vbl_close;
    shell_pkg::count_t pix_cnt;
    shell_pkg::count_t line_cnt;

    // hblank fell since the last pixel
    assign line_start = hbl_prev & ~src_hblank;
    // window vblank about to set
    assign vbl_close  = (line_cnt == cfg.v_end) & ~window_vblank;

    ////////////////////
    // counters

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            hbl_prev <= 1'b0;
            vbl_prev <= 1'b0;
            pix_cnt  <= '0;
            line_cnt <= '0;
        end else if (pix_ce) begin
            hbl_prev <= src_hblank;
            pix_cnt  <= pix_cnt + 11'd1;
            if (line_start) begin
                pix_cnt  <= '0;
                // vblank edge only looked at once per line
                vbl_prev <= src_vblank;
                line_cnt <= line_cnt + 11'd1;
                if (vbl_prev & ~src_vblank) begin
                    line_cnt <= '0;
                end
            end
        end
    end

    ////////////////////
    // window flags

    // end bound wins if both match
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            window_hblank  <= 1'b1;
            window_vblank  <= 1'b1;
            cfg.frame_tick <= 1'b0;
        end else begin
            cfg.frame_tick <= pix_ce & vbl_close;
            if (pix_ce) begin
                if (pix_cnt == cfg.h_start)  window_hblank <= 1'b0;
                if (pix_cnt == cfg.h_end)    window_hblank <= 1'b1;
                if (line_cnt == cfg.v_start) window_vblank <= 1'b0;
                if (line_cnt == cfg.v_end)   window_vblank <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/video_result.sv ====
////////////////////
// video output stage
// grey palette to rgb, data enable, sync pulses
////////////////////

`timescale 1ns/100ps
`default_nettype none

module video_result (
    input  wire                clk_sys,
    input  wire                rst_n,
    input  wire                video_white,
    input  wire                video_black,
    input  wire                src_hs,
    input  wire                src_vs,
    input  wire                window_hblank,
    input  wire                window_vblank,
    shell_cfg_if.video         cfg,
    output shell_pkg::rgb_t    video_rgb,
    output logic               video_de,
    output logic               video_hs,
    output logic               video_vs
);

    shell_pkg::colour_code_t code;
    shell_pkg::grey_t        grey;
    logic                    active;
    logic                    hs_prev;
    logic                    vs_prev;

    // white is the upper bit
    assign code   = {video_white, video_black};
    assign grey   = cfg.palette[code];
    assign active = ~(window_hblank | window_vblank);

    ////////////////////
    // pixel register

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            video_de  <= 1'b0;
            video_rgb <= '0;
        end else begin
            video_de  <= active;
            // same grey on all three channels
            video_rgb <= active ? {3{grey}} : '0;
        end
    end

    ////////////////////
    // sync edges

    // single cycle pulse per rising edge
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            hs_prev  <= 1'b0;
            vs_prev  <= 1'b0;
            video_hs <= 1'b0;
            video_vs <= 1'b0;
        end else begin
            hs_prev  <= src_hs;
            vs_prev  <= src_vs;
            video_hs <= src_hs & ~hs_prev;
            video_vs <= src_vs & ~vs_prev;
        end
    end

endmodule

`default_nettype wire

// ==== logic/i2s_serializer.sv ====
////////////////////
// i2s audio serializer
// sclk from clk_sys, 32 slots per channel,
// 16 sample bits msb first then zeros
////////////////////

`timescale 1ns/100ps
`default_nettype none

module i2s_serializer #(
    parameter int SCLK_DIV = 4
) (
    input  wire                   clk_sys,
    input  wire                   rst_n,
    input  wire shell_pkg::sample_t audio_sample,
    output logic                  i2s_sclk,
    output logic                  i2s_lrck,
    output logic                  i2s_dac
);

    // clk_sys cycles per sclk half period
    localparam int HALF  = SCLK_DIV / 2;
    localparam int DIV_W = (HALF > 1) ? $clog2(HALF) : 1;

    logic [DIV_W-1:0]      div_cnt;
    logic                  half_done;
    logic                  sclk_fall;
    logic                  chan_end;
    logic [4:0]            slot;
    shell_pkg::i2s_state_e chan;
    shell_pkg::sample_t    sample_q;
    shell_pkg::sample_t    shift_q;

    assign half_done = (div_cnt == DIV_W'(HALF - 1));
    // high half ends here, outputs move on this edge
    assign sclk_fall = half_done & i2s_sclk;
    assign chan_end  = sclk_fall & (slot == 5'd31);
    // lrck high on the right channel
    assign i2s_lrck  = (chan == shell_pkg::I2S_RIGHT);

    ////////////////////
    // sclk divider

    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt  <= '0;
            i2s_sclk <= 1'b0;
        end else if (half_done) begin
            div_cnt  <= '0;
            i2s_sclk <= ~i2s_sclk;
        end else begin
            div_cnt  <= div_cnt + 1'b1;
        end
    end

    // sample held for the right channel
    always_ff @(posedge clk_sys) begin
        if (chan_end && chan == shell_pkg::I2S_RIGHT) begin
            sample_q <= audio_sample;
        end
    end

    ////////////////////
    // slots and shifter

    // msb goes out in the same slot as the lrck change
    always_ff @(posedge clk_sys or negedge rst_n) begin
        if (!rst_n) begin
            slot    <= '0;
            chan    <= shell_pkg::I2S_RIGHT;
            shift_q <= '0;
            i2s_dac <= 1'b0;
        end else if (sclk_fall) begin
            slot <= slot + 5'd1;
            if (chan_end) begin
                if (chan == shell_pkg::I2S_RIGHT) begin
                    // new left channel, take a fresh sample
                    chan    <= shell_pkg::I2S_LEFT;
                    i2s_dac <= audio_sample[15];
                    shift_q <= {audio_sample[14:0], 1'b0};
                end else begin
                    chan    <= shell_pkg::I2S_RIGHT;
                    i2s_dac <= sample_q[15];
                    shift_q <= {sample_q[14:0], 1'b0};
                end
            end else begin
                // zeros shift in, slots 16..31 come out low
                i2s_dac <= shift_q[15];
                shift_q <= {shift_q[14:0], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/shell_top.sv ====
////////////////////
// arcade output shell top
// apb registers, window rebuild, video out, i2s out
////////////////////

`timescale 1ns/100ps
`default_nettype none

module shell_top #(
    parameter int SCLK_DIV = 4
) (
    input  wire                       clk_sys,
    input  wire                       rst_n,
    // apb slave
    input  wire                       psel,
    input  wire                       penable,
    input  wire                       pwrite,
    input  wire shell_pkg::apb_addr_t paddr,
    input  wire shell_pkg::apb_data_t pwdata,
    output wire shell_pkg::apb_data_t prdata,
    output wire                       pready,
    output wire                       pslverr,
    // raw game core video
    input  wire                       pix_ce,
    input  wire                       video_white,
    input  wire                       video_black,
    input  wire                       src_hblank,
    input  wire                       src_vblank,
    input  wire                       src_hs,
    input  wire                       src_vs,
    input  wire shell_pkg::sample_t   audio_sample,
    // scaler side
    output wire shell_pkg::rgb_t      video_rgb,
    output wire                       video_de,
    output wire                       video_hs,
    output wire                       video_vs,
    output wire                       i2s_sclk,
    output wire                       i2s_lrck,
    output wire                       i2s_dac
);

    wire window_hblank;
    wire window_vblank;

    shell_cfg_if cfg_if ();

    ////////////////////
    // control path

    apb_reg_decode i_decode (
        .clk_sys (clk_sys),
        .rst_n   (rst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cfg     (cfg_if)
    );

    ////////////////////
    // video path

    blank_window i_execute (
        .clk_sys       (clk_sys),
        .rst_n         (rst_n),
        .pix_ce        (pix_ce),
        .src_hblank    (src_hblank),
        .src_vblank    (src_vblank),
        .cfg           (cfg_if),
        .window_hblank (window_hblank),
        .window_vblank (window_vblank)
    );

    video_result i_result (
        .clk_sys       (clk_sys),
        .rst_n         (rst_n),
        .video_white   (video_white),
        .video_black   (video_black),
        .src_hs        (src_hs),
        .src_vs        (src_vs),
        .window_hblank (window_hblank),
        .window_vblank (window_vblank),
        .cfg           (cfg_if),
        .video_rgb     (video_rgb),
        .video_de      (video_de),
        .video_hs      (video_hs),
        .video_vs      (video_vs)
    );

    // audio out
    i2s_serializer #(
        .SCLK_DIV (SCLK_DIV)
    ) i_i2s (
        .clk_sys      (clk_sys),
        .rst_n        (rst_n),
        .audio_sample (audio_sample),
        .i2s_sclk     (i2s_sclk),
        .i2s_lrck     (i2s_lrck),
        .i2s_dac      (i2s_dac)
    );

endmodule

`default_nettype wire

// ==== testbench/tb_shell.sv ====
////////////////////
// testbench for the arcade output shell
// apb register access, window rebuild, rgb, sync pulses, i2s
////////////////////

`timescale 1ns/100ps
`default_nettype none

module tb_shell;

    localparam int SCLK_DIV = 4;
    localparam int CLK_NS   = 4;

    logic        clk_sys;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        pix_ce;
    logic        video_white;
    logic        video_black;
    logic        src_hblank;
    logic        src_vblank;
    logic        src_hs;
    logic        src_vs;
    logic [15:0] audio_sample;
    logic [23:0] video_rgb;
    logic        video_de;
    logic        video_hs;
    logic        video_vs;
    logic        i2s_sclk;
    logic        i2s_lrck;
    logic        i2s_dac;

    // shadow copy of the programmed registers
    logic [31:0] pal_w = 32'hFF865000;
    int          hs_w  = 6;
    int          he_w  = 326;
    int          vs_w  = 0;
    int          ve_w  = 241;

    logic [31:0] rng   = 32'he18a3daf;
    logic [1:0]  code_q = 2'd0;
    logic        hs_q  = 1'b0;
    logic        hs_qq = 1'b0;
    logic        vs_q  = 1'b0;
    logic        vs_qq = 1'b0;
    logic        primed = 1'b0;
    time         deadline = 1000;

    shell_top #(
        .SCLK_DIV (SCLK_DIV)
    ) i_dut (
        .clk_sys      (clk_sys),
        .rst_n        (rst_n),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .pix_ce       (pix_ce),
        .video_white  (video_white),
        .video_black  (video_black),
        .src_hblank   (src_hblank),
        .src_vblank   (src_vblank),
        .src_hs       (src_hs),
        .src_vs       (src_vs),
        .audio_sample (audio_sample),
        .video_rgb    (video_rgb),
        .video_de     (video_de),
        .video_hs     (video_hs),
        .video_vs     (video_vs),
        .i2s_sclk     (i2s_sclk),
        .i2s_lrck     (i2s_lrck),
        .i2s_dac      (i2s_dac)
    );

    // 4 ns clock
    always #2 clk_sys = ~clk_sys;

    // run limit moved forward by each case
    always @(negedge clk_sys) begin
        if ($time > deadline) begin
            fail_run("timeout: the run went past the time budget of its cases");
        end
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic set_budget(input int clocks);
        deadline = $time + (clocks + 50) * CLK_NS;
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // setup, access, then idle
    task automatic apb_access(input logic wr, input logic [11:0] addr,
                              input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        @(negedge clk_sys);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk_sys);
        penable = 1'b1;
        assert (pready === 1'b1) else fail_run($sformatf(
            "error %0t ns: pready is %b in the access phase", $time, pready));
        rdata = prdata;
        err   = pslverr;
        @(negedge clk_sys);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // one clk_sys cycle of video with outputs checked before new inputs
    task automatic video_tick(input logic ce, input logic hbl, input logic vbl,
                              input logic hs, input logic vs, input logic de_exp);
        logic [7:0] g;
        @(negedge clk_sys);
        g = pal_w[8*code_q +: 8];
        if (primed) begin
            assert (video_de === de_exp) else fail_run($sformatf(
                "error %0t ns: video_de is %b, expected %b", $time, video_de, de_exp));
            assert (video_rgb === (de_exp ? {3{g}} : 24'd0)) else fail_run($sformatf(
                "error %0t ns: video_rgb is %h for code %0d", $time, video_rgb, code_q));
        end
        assert (video_hs === (hs_q & ~hs_qq)) else fail_run($sformatf(
            "error %0t ns: video_hs is %b after src_hs %b%b", $time, video_hs, hs_qq, hs_q));
        assert (video_vs === (vs_q & ~vs_qq)) else fail_run($sformatf(
            "error %0t ns: video_vs is %b after src_vs %b%b", $time, video_vs, vs_qq, vs_q));
        rng         = xorshift(rng);
        code_q      = rng[1:0];
        video_white = rng[1];
        video_black = rng[0];
        pix_ce      = ce;
        src_hblank  = hbl;
        src_vblank  = vbl;
        src_hs      = hs;
        src_vs      = vs;
        hs_qq       = hs_q;
        hs_q        = hs;
        vs_qq       = vs_q;
        vs_q        = vs;
    endtask

    // one pixel is a pix_ce cycle and an idle cycle
    task automatic drive_pixel(input logic hbl, input logic vbl, input logic hs,
                               input logic vs, input logic de_exp);
        video_tick(1'b1, hbl, vbl, hs, vs, de_exp);
        video_tick(1'b0, hbl, vbl, hs, vs, de_exp);
    endtask

    task automatic run_frames(input int nf, input int va, input int vb,
                              input int nl, input int nh);
        logic exp;
        set_budget((nf + 1) * (va + vb) * (nl + nh) * 2);
        // one blank line so the first frame sees vblank fall
        if (!primed) begin
            for (int p = 0; p < nh + nl + nh; p++) begin
                drive_pixel(p < nh || p >= nh + nl, 1'b1, 1'b0, 1'b0, 1'b0);
            end
            primed = 1'b1;
        end
        for (int f = 0; f < nf; f++) begin
            for (int l = 0; l < va + vb; l++) begin
                for (int p = 0; p < nl + nh; p++) begin
                    // register stage puts de at counted pixels start+2 .. end+1
                    exp = (l >= vs_w) && (l < ve_w) && (p >= hs_w + 2) && (p <= he_w + 1);
                    drive_pixel(p >= nl, l >= va, (p == nl) || (p == nl + 1), l == va, exp);
                end
            end
        end
    endtask

    // left and right channel of one sample with bits taken on rising sclk
    task automatic audio_frame(input logic [15:0] s);
        logic lr_prev;
        logic sclk_prev;
        logic exp_bit;
        int   n;
        int   slot;
        set_budget(3 * 64 * SCLK_DIV);
        @(negedge clk_sys);
        audio_sample = s;
        lr_prev = i2s_lrck;
        @(negedge clk_sys);
        while (!(lr_prev && !i2s_lrck)) begin
            lr_prev = i2s_lrck;
            @(negedge clk_sys);
        end
        sclk_prev = i2s_sclk;
        n = 0;
        while (n < 64) begin
            @(negedge clk_sys);
            if (i2s_sclk && !sclk_prev) begin
                slot    = n % 32;
                exp_bit = (slot < 16) ? s[15 - slot] : 1'b0;
                assert (i2s_dac === exp_bit) else fail_run($sformatf(
                    "error %0t ns: i2s_dac slot %0d of bit %0d is %b, sample %h",
                    $time, slot, n, i2s_dac, s));
                assert (i2s_lrck === (n >= 32)) else fail_run($sformatf(
                    "error %0t ns: i2s_lrck is %b at bit %0d", $time, i2s_lrck, n));
                n++;
            end
            sclk_prev = i2s_sclk;
        end
    endtask

    initial begin
        int          fd;
        int          code;
        string       kw;
        string       rest;
        logic [31:0] wr;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] err_exp;
        logic [31:0] rdata;
        logic        err;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        logic [31:0] f5;
        clk_sys      = 1'b0;
        rst_n        = 1'b0;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        pix_ce       = 1'b0;
        video_white  = 1'b0;
        video_black  = 1'b0;
        src_hblank   = 1'b0;
        src_vblank   = 1'b0;
        src_hs       = 1'b0;
        src_vs       = 1'b0;
        audio_sample = '0;
        repeat (10) @(negedge clk_sys);
        // outputs still held by reset
        assert (pslverr === 1'b0 && prdata === 32'd0 && video_de === 1'b0 &&
                video_rgb === 24'd0 && video_hs === 1'b0 && video_vs === 1'b0 &&
                i2s_sclk === 1'b0 && i2s_dac === 1'b0 && i2s_lrck === 1'b1)
            else fail_run($sformatf("error %0t ns: wrong output value in reset", $time));
        rst_n = 1'b1;
        fd = $fopen("testbench/shell_cases.txt", "r");
        if (fd == 0) begin
            fail_run("could not open the case file testbench/shell_cases.txt");
        end
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", kw);
            if (code != 1) break;
            if (kw.getc(0) == "#") begin
                code = $fgets(rest, fd);
            end else if (kw == "apb") begin
                code = $fscanf(fd, "%h %h %h %h", wr, addr, data, err_exp);
                set_budget(10);
                apb_access(wr[0], addr[11:0], data, rdata, err);
                assert (err === err_exp[0]) else fail_run($sformatf(
                    "error %0t ns: pslverr %b at address %h", $time, err, addr[11:0]));
                if (!wr[0]) begin
                    assert (rdata === data) else fail_run($sformatf(
                        "error %0t ns: read %h from %h, expected %h",
                        $time, rdata, addr[11:0], data));
                end else if (!err_exp[0]) begin
                    case (addr[11:0])
                        12'h004: pal_w = data;
                        12'h008: begin
                            hs_w = data[10:0];
                            he_w = data[26:16];
                        end
                        12'h00C: begin
                            vs_w = data[10:0];
                            ve_w = data[26:16];
                        end
                        default: ;
                    endcase
                end
            end else if (kw == "line") begin
                code = $fscanf(fd, "%h %h %h %h %h", f1, f2, f3, f4, f5);
                run_frames(f1, f2, f3, f4, f5);
            end else if (kw == "audio") begin
                code = $fscanf(fd, "%h %h", f1, f2);
                audio_frame(f1[15:0]);
                for (int i = 0; i < f2; i++) begin
                    rng = xorshift(rng);
                    audio_frame(rng[15:0]);
                end
            end else begin
                fail_run($sformatf("unknown keyword %s in the case file", kw));
            end
        end
        $fclose(fd);
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/shell_cases.txt ====
# fields in hex: apb <write> <addr> <data> <pslverr>, reads expect data
# line <frames> <active lines> <blank lines> <low pixels> <high pixels>
# audio <sample> <random frames after it>
apb 0 000 444D4E31 0
apb 0 004 FF865000 0
apb 0 008 01460006 0
apb 0 00C 00F10000 0
apb 0 010 00000000 0
apb 0 014 00000000 1
apb 1 000 12345678 1
apb 0 000 444D4E31 0
apb 1 010 0000ABCD 1
apb 0 010 00000000 0
apb 1 008 000C0003 0
apb 0 008 000C0003 0
apb 1 00C 00050002 0
apb 0 00C 00050002 0
line 2 6 2 C 6
apb 0 010 00000002 0
apb 1 004 F0A03010 0
apb 0 004 F0A03010 0
line 1 6 2 C 6
apb 0 010 00000003 0
apb 1 008 00100001 0
apb 0 008 00100001 0
apb 1 00C 00030001 0
apb 0 00C 00030001 0
line 2 5 3 E 6
apb 0 010 00000005 0
audio A5C3 0
audio 8001 2
audio 7FFE 1

// ==== src.f ====
logic/shell_pkg.sv
logic/shell_cfg_if.sv
logic/apb_reg_decode.sv
logic/blank_window.sv
logic/video_result.sv
logic/i2s_serializer.sv
logic/shell_top.sv
testbench/tb_shell.sv
